//--- Makefile
.PHONY: all run clean

all: obj_dir/Vtb_mem_subsys

obj_dir/Vtb_mem_subsys: src.f $(wildcard source/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f src.f

run: obj_dir/Vtb_mem_subsys
	@out="$$(./obj_dir/Vtb_mem_subsys)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- source/channel_arb.sv
`timescale 1ns/1ps
`default_nettype none

// Fixed-priority arbiter that serves stores first, then loads, then instruction bursts
module channel_arb (
    input  logic                             ddr_operation_done,
    output logic                             arb_operation_done,

    // Instruction fetch channel
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  pc_index,            // Line index of the burst
    input  logic                             pc_index_valid,      // Held until ready
    output logic                             pc_index_ready,      // One-cycle grant

    // Store channel, fed from the posting queue
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  sw_index,
    input  logic                             sw_index_valid,
    input  logic [mem_pkg::WORD_W-1:0]       sw2arb_write_mask,   // Head mask
    input  logic [mem_pkg::WORD_W-1:0]       sw2ddr_write_data,   // Head data
    output logic                             sw_index_ready,      // Pops the queue head

    // Load channel
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  lw_index,
    input  logic                             lw_index_valid,
    output logic                             lw_index_ready,

    // Memory controller side
    input  logic                             ddr_ready,           // Controller free
    output logic [mem_pkg::DDR_INDEX_W-1:0]  ddr_index,           // Index of the winner
    output logic                             burst_mode,          // Whole-line read
    output logic                             chip_enable,         // Start of an operation
    output logic                             write_enable,        // Store operation
    output logic [mem_pkg::WORD_W-1:0]       sw_write_mask,
    output logic [mem_pkg::WORD_W-1:0]       sw_write_data
);

    assign arb_operation_done = ddr_operation_done;  // Completion goes to the router

    always_comb begin
        chip_enable    = 1'b0;  // Nothing granted by default
        burst_mode     = 1'b0;
        write_enable   = 1'b0;
        ddr_index      = '0;
        sw_write_mask  = '0;
        sw_write_data  = '0;
        pc_index_ready = 1'b0;
        sw_index_ready = 1'b0;
        lw_index_ready = 1'b0;

        if (ddr_ready) begin  // A busy controller withholds every grant
            if (sw_index_valid) begin
                ddr_index      = sw_index;           // Store wins
                chip_enable    = 1'b1;
                write_enable   = 1'b1;
                sw_write_mask  = sw2arb_write_mask;
                sw_write_data  = sw2ddr_write_data;
                sw_index_ready = 1'b1;
            end else if (lw_index_valid) begin
                ddr_index      = lw_index;           // Single word read
                chip_enable    = 1'b1;
                lw_index_ready = 1'b1;
            end else if (pc_index_valid) begin
                ddr_index      = pc_index;           // Line read for the fetch unit
                chip_enable    = 1'b1;
                burst_mode     = 1'b1;
                pc_index_ready = 1'b1;
            end
        end

        // The router relies on a single grant per accepted operation
        a_ready_onehot : assert ($onehot0({sw_index_ready, lw_index_ready, pc_index_ready}));
        a_ce_matches : assert (chip_enable == (sw_index_ready | lw_index_ready | pc_index_ready));
    end

endmodule

`default_nettype wire

//--- source/ddr_model.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral memory controller with a fixed access latency
module ddr_model #(
    parameter int DDR_LATENCY = 4,                                  // Accept to done, at least 2
    parameter int MEM_LINES   = 16                                  // Lines of storage
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             chip_enable,         // Operation request
    input  logic                             write_enable,
    input  logic                             burst_mode,
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  ddr_index,
    input  logic [mem_pkg::WORD_W-1:0]       sw_write_mask,
    input  logic [mem_pkg::WORD_W-1:0]       sw_write_data,
    output logic                             ddr_ready,           // Free for a new operation
    output logic                             ddr_operation_done,  // One-cycle completion
    output logic [mem_pkg::WORD_W-1:0]       lw_read_data,        // Selected word
    output logic [mem_pkg::LINE_W-1:0]       fetch_burst_read_inst // Whole line
);
    import mem_pkg::*;

    localparam int LINE_AW = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;
    localparam int CNT_W   = $clog2(DDR_LATENCY + 1);

    mem_line_u mem [MEM_LINES];  // Storage array

    logic                   accept;
    logic                   busy;      // Operation in flight
    logic [CNT_W-1:0]       cnt;       // Cycles left before done
    logic                   op_we;     // Latched operation
    logic [DDR_INDEX_W-1:0] op_index;
    logic [WORD_W-1:0]      op_mask;
    logic [WORD_W-1:0]      op_data;
    logic [LINE_AW-1:0]     line_sel;
    logic [WORD_SEL_W-1:0]  word_sel;
    mem_line_u              cur_line;  // Line addressed by the latched index

    assign accept   = chip_enable && ddr_ready;
    assign word_sel = op_index[WORD_SEL_W-1:0];
    assign line_sel = LINE_AW'(op_index[DDR_INDEX_W-1:LINE_SEL_LSB] % MEM_LINES);  // Wraps
    assign cur_line = mem[line_sel];

    // Both views are always driven; the router picks what it needs
    assign lw_read_data          = cur_line.words[word_sel];
    assign fetch_burst_read_inst = cur_line.bits;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_we    <= write_enable;
            op_index <= ddr_index;
            op_mask  <= sw_write_mask;
            op_data  <= sw_write_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ddr_ready          <= 1'b0;
            ddr_operation_done <= 1'b0;
            busy               <= 1'b0;
            cnt                <= '0;
            for (int i = 0; i < MEM_LINES; i++) begin
                mem[i] <= '0;  // Memory starts out zero
            end
        end else if (accept) begin
            ddr_ready <= 1'b0;                      // Busy from this edge on
            busy      <= 1'b1;
            cnt       <= CNT_W'(DDR_LATENCY - 2);
        end else if (ddr_operation_done) begin
            ddr_operation_done <= 1'b0;             // Edge that ends the done cycle
            busy               <= 1'b0;
            ddr_ready          <= 1'b1;
            if (op_we) begin
                // Masked merge where ones in the mask take new data
                mem[line_sel].words[word_sel] <=
                    (cur_line.words[word_sel] & ~op_mask) | (op_data & op_mask);
            end
        end else if (busy) begin
            if (cnt == '0) begin
                ddr_operation_done <= 1'b1;         // Latency elapsed
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else begin
            ddr_ready <= 1'b1;                      // First cycle out of reset
        end
    end

    // The arbiter must gate requests with ddr_ready
    a_ce_when_busy : assert property (@(posedge clk) disable iff (!arst_n)
        chip_enable |-> ddr_ready);

    // Burst reads never carry a store
    a_burst_is_read : assert property (@(posedge clk) disable iff (!arst_n)
        (chip_enable && burst_mode) |-> !write_enable);

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Address and data widths of the memory path
    localparam int DDR_INDEX_W    = 19;   // Word index width
    localparam int WORD_W         = 64;   // Data word and write mask width
    localparam int LINE_W         = 512;  // One memory line
    localparam int WORDS_PER_LINE = 8;    // Words packed into a line
    localparam int WORD_SEL_W     = 3;    // Low index bits pick the word in a line

    // Index layout
    //   [WORD_SEL_W-1:0]           word within the line
    //   [DDR_INDEX_W-1:WORD_SEL_W] line number, taken modulo the line count
    localparam int LINE_SEL_LSB = WORD_SEL_W;  // First bit of the line field
    localparam int LINE_SEL_W   = DDR_INDEX_W - WORD_SEL_W;  // Width of the line field

    // One memory line, seen either whole or as separate words
    typedef union packed {
        logic [LINE_W-1:0]                     bits;   // Instruction burst view
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;  // Load and store view
    } mem_line_u;

endpackage

`default_nettype wire

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int SWQ_DEPTH   = 4,
    parameter int DDR_LATENCY = 4,
    parameter int MEM_LINES   = 16
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             sw_store_valid,
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  sw_store_index,
    input  logic [mem_pkg::WORD_W-1:0]       sw_store_mask,
    input  logic [mem_pkg::WORD_W-1:0]       sw_store_data,
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  lw_index,
    input  logic                             lw_index_valid,
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  pc_index,
    input  logic                             pc_index_valid,
    output logic                             sw_store_full,
    output logic                             lw_index_ready,
    output logic                             pc_index_ready,
    output logic [mem_pkg::WORD_W-1:0]       arb2lw_read_data,
    output logic [mem_pkg::LINE_W-1:0]       arb2ib_read_inst,
    output logic                             sw_write_done,
    output logic                             lw_read_done,
    output logic                             ib_read_done
);
    import mem_pkg::*;

    logic                   sw_index_valid;      // Queue head to arbiter
    logic [DDR_INDEX_W-1:0] sw_index;
    logic [WORD_W-1:0]      sw2arb_write_mask;
    logic [WORD_W-1:0]      sw2ddr_write_data;
    logic                   sw_index_ready;
    logic                   ddr_ready;           // Arbiter and controller
    logic [DDR_INDEX_W-1:0] ddr_index;
    logic                   burst_mode;
    logic                   chip_enable;
    logic                   write_enable;
    logic [WORD_W-1:0]      sw_write_mask;
    logic [WORD_W-1:0]      sw_write_data;
    logic                   ddr_operation_done;
    logic                   arb_operation_done;  // Completion to the router
    logic [WORD_W-1:0]      lw_read_data;
    logic [LINE_W-1:0]      fetch_burst_read_inst;

    sw_write_queue #(.SWQ_DEPTH(SWQ_DEPTH)) sw_write_queue_i (
        .clk, .arst_n, .sw_store_valid, .sw_store_index, .sw_store_mask, .sw_store_data,
        .sw_index_ready, .sw_store_full, .sw_index_valid, .sw_index, .sw2arb_write_mask,
        .sw2ddr_write_data
    );

    channel_arb channel_arb_i (
        .ddr_operation_done, .arb_operation_done, .pc_index, .pc_index_valid, .pc_index_ready,
        .sw_index, .sw_index_valid, .sw2arb_write_mask, .sw2ddr_write_data, .sw_index_ready,
        .lw_index, .lw_index_valid, .lw_index_ready, .ddr_ready, .ddr_index, .burst_mode,
        .chip_enable, .write_enable, .sw_write_mask, .sw_write_data
    );

    ddr_model #(.DDR_LATENCY(DDR_LATENCY), .MEM_LINES(MEM_LINES)) ddr_model_i (
        .clk, .arst_n, .chip_enable, .write_enable, .burst_mode, .ddr_index, .sw_write_mask,
        .sw_write_data, .ddr_ready, .ddr_operation_done, .lw_read_data, .fetch_burst_read_inst
    );

    read_return_router read_return_router_i (
        .clk, .arst_n, .sw_index_ready, .lw_index_ready, .pc_index_ready, .arb_operation_done,
        .lw_read_data, .fetch_burst_read_inst, .arb2lw_read_data, .arb2ib_read_inst,
        .sw_write_done, .lw_read_done, .ib_read_done
    );

endmodule

`default_nettype wire

//--- source/read_return_router.sv
`timescale 1ns/1ps
`default_nettype none

// Sends completions and read data back to the channel that was granted
module read_return_router (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             sw_index_ready,      // Grant pulses from the arbiter
    input  logic                             lw_index_ready,
    input  logic                             pc_index_ready,
    input  logic                             arb_operation_done,  // Controller done cycle
    input  logic [mem_pkg::WORD_W-1:0]       lw_read_data,
    input  logic [mem_pkg::LINE_W-1:0]       fetch_burst_read_inst,
    output logic [mem_pkg::WORD_W-1:0]       arb2lw_read_data,    // Held until the next load
    output logic [mem_pkg::LINE_W-1:0]       arb2ib_read_inst,    // Held until the next burst
    output logic                             sw_write_done,
    output logic                             lw_read_done,
    output logic                             ib_read_done
);

    logic [2:0] grant;    // Readies of this cycle, sw lw pc
    logic [2:0] pend_q;   // Channel of the operation in flight
    logic       pending;

    assign grant   = {sw_index_ready, lw_index_ready, pc_index_ready};
    assign pending = |pend_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_q        <= '0;
            sw_write_done <= 1'b0;
            lw_read_done  <= 1'b0;
            ib_read_done  <= 1'b0;
        end else begin
            sw_write_done <= arb_operation_done && pend_q[2];  // One strobe per operation
            lw_read_done  <= arb_operation_done && pend_q[1];
            ib_read_done  <= arb_operation_done && pend_q[0];
            if (|grant) begin
                pend_q <= grant;                               // Accept edge
            end else if (arb_operation_done) begin
                pend_q <= '0;
            end
        end
    end

    // Data is sampled in the done cycle of a read of its own kind
    always_ff @(posedge clk) begin
        if (arb_operation_done && pend_q[1]) begin
            arb2lw_read_data <= lw_read_data;
        end
        if (arb_operation_done && pend_q[0]) begin
            arb2ib_read_inst <= fetch_burst_read_inst;
        end
    end

    // Every completion belongs to an earlier grant
    a_done_has_owner : assert property (@(posedge clk) disable iff (!arst_n)
        arb_operation_done |-> pending);

endmodule

`default_nettype wire

//--- source/sw_write_queue.sv
`timescale 1ns/1ps
`default_nettype none

// Posting queue for store words; the head waits here until the arbiter grants it
module sw_write_queue #(
    parameter int SWQ_DEPTH = 4                                   // Number of posted stores
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             sw_store_valid,     // One-cycle push strobe
    input  logic [mem_pkg::DDR_INDEX_W-1:0]  sw_store_index,
    input  logic [mem_pkg::WORD_W-1:0]       sw_store_mask,
    input  logic [mem_pkg::WORD_W-1:0]       sw_store_data,
    input  logic                             sw_index_ready,     // Grant pulse pops the head
    output logic                             sw_store_full,
    output logic                             sw_index_valid,     // Head present
    output logic [mem_pkg::DDR_INDEX_W-1:0]  sw_index,
    output logic [mem_pkg::WORD_W-1:0]       sw2arb_write_mask,
    output logic [mem_pkg::WORD_W-1:0]       sw2ddr_write_data
);
    import mem_pkg::*;

    localparam int PTR_W = (SWQ_DEPTH > 1) ? $clog2(SWQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SWQ_DEPTH + 1);

    logic [DDR_INDEX_W-1:0] index_mem [SWQ_DEPTH];  // Entry payload
    logic [WORD_W-1:0]      mask_mem  [SWQ_DEPTH];
    logic [WORD_W-1:0]      data_mem  [SWQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push = sw_store_valid;
    assign pop  = sw_index_ready;

    // Pointers wrap at the depth, so any depth works
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(SWQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(SWQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;  // Push only
                2'b01:   count <= count - 1'b1;  // Pop only
                default: count <= count;         // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            index_mem[wr_ptr] <= sw_store_index;
            mask_mem[wr_ptr]  <= sw_store_mask;
            data_mem[wr_ptr]  <= sw_store_data;
        end
    end

    assign sw_store_full     = (count == CNT_W'(SWQ_DEPTH));
    assign sw_index_valid    = (count != '0);  // Held until the grant
    assign sw_index          = index_mem[rd_ptr];
    assign sw2arb_write_mask = mask_mem[rd_ptr];
    assign sw2ddr_write_data = data_mem[rd_ptr];

    // The requester must respect the full flag
    a_no_push_full : assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !sw_store_full);

    // Grant only ever arrives for a presented head
    a_no_pop_empty : assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> sw_index_valid);

endmodule

`default_nettype wire

//--- src.f
source/mem_pkg.sv
source/sw_write_queue.sv
source/channel_arb.sv
source/ddr_model.sv
source/read_return_router.sv
source/mem_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_subsys.sv

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock with a reset held over the first cycles
module tb_clock_gen #(
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;  // Reset from time zero
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;  // Released off the edge
    end

    always #4 clk = ~clk;  // 8 ns period

endmodule

`default_nettype wire

//--- testbench/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int SWQ_DEPTH   = 4;
    localparam int DDR_LATENCY = 4;
    localparam int MEM_LINES   = 16;
    localparam int TIMEOUT     = 200;  // Cycles allowed per wait
    localparam int NROWS       = 13;
    localparam logic [2:0] K_STORE = 3'd0, K_LOAD = 3'd1, K_FETCH = 3'd2;
    localparam logic [2:0] K_PAR = 3'd3, K_FILL = 3'd4;  // Parallel run and queue fill under a load

    typedef struct packed {
        logic [2:0]             kind;
        logic [DDR_INDEX_W-1:0] index;
        logic [WORD_W-1:0]      mask;
        logic [WORD_W-1:0]      data;
        logic [WORD_W-1:0]      exp_word;
        mem_line_u              exp_line;
    } row_t;

    logic                   clk;
    logic                   arst_n;
    logic                   sw_store_valid;
    logic [DDR_INDEX_W-1:0] sw_store_index;
    logic [WORD_W-1:0]      sw_store_mask;
    logic [WORD_W-1:0]      sw_store_data;
    logic [DDR_INDEX_W-1:0] lw_index;
    logic                   lw_index_valid;
    logic [DDR_INDEX_W-1:0] pc_index;
    logic                   pc_index_valid;
    logic                   sw_store_full;
    logic                   lw_index_ready;
    logic                   pc_index_ready;
    logic [WORD_W-1:0]      arb2lw_read_data;
    logic [LINE_W-1:0]      arb2ib_read_inst;
    logic                   sw_write_done;
    logic                   lw_read_done;
    logic                   ib_read_done;

    row_t        rows [NROWS];
    mem_line_u   ref_mem [MEM_LINES];  // Reference memory
    logic [WORD_W-1:0] fill_data [SWQ_DEPTH];
    int          val_errs = 0;
    int          order_errs = 0;
    int          cycle = 0;

    tb_clock_gen #(.RST_CYCLES(10)) tb_clock_gen_i (.clk, .arst_n);

    mem_subsys_top #(
        .SWQ_DEPTH(SWQ_DEPTH), .DDR_LATENCY(DDR_LATENCY), .MEM_LINES(MEM_LINES)
    ) mem_subsys_top_i (
        .clk, .arst_n, .sw_store_valid, .sw_store_index, .sw_store_mask, .sw_store_data,
        .lw_index, .lw_index_valid, .pc_index, .pc_index_valid, .sw_store_full,
        .lw_index_ready, .pc_index_ready, .arb2lw_read_data, .arb2ib_read_inst,
        .sw_write_done, .lw_read_done, .ib_read_done
    );

    always @(posedge clk) cycle <= cycle + 1;  // Read at negedge only

    function automatic int line_of(input logic [DDR_INDEX_W-1:0] idx);
        return int'(idx[DDR_INDEX_W-1:WORD_SEL_W]) % MEM_LINES;
    endfunction

    // Masked write rule where ones in the mask take the new data
    task automatic ref_write(input logic [DDR_INDEX_W-1:0] idx, input logic [WORD_W-1:0] mask,
                             input logic [WORD_W-1:0] data);
        logic [WORD_W-1:0] old;
        old = ref_mem[line_of(idx)].words[idx[WORD_SEL_W-1:0]];
        ref_mem[line_of(idx)].words[idx[WORD_SEL_W-1:0]] = (old & ~mask) | (data & mask);
    endtask

    task automatic check_word(input string what, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s read %h, expected %h", $time, what, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_line(input string what, input mem_line_u got, input mem_line_u exp);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (got.words[w] !== exp.words[w]) begin
                $display("ERR %0t ns: %s word %0d is %h, expected %h", $time, what, w,
                         got.words[w], exp.words[w]);
                val_errs++;
            end
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
            val_errs++;
        end
    endtask

    // Codes 0 store, 1 load, 2 fetch
    task automatic check_order(input string what, input int pos, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t ns: %s position %0d is channel %0d, expected %0d", $time, what,
                     pos, got, exp);
            order_errs++;
        end
    endtask

    task automatic give_up(input string what);
        $display("Timed out waiting for %s at %0t ns", what, $time);
        $display("Errors: %0d value, %0d order, 1 timeout", val_errs, order_errs);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic wait_not_full();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (sw_store_full && t < TIMEOUT);
        if (sw_store_full) give_up("the store queue to drain");
    endtask

    task automatic do_store(input row_t r);
        int t;
        wait_not_full();
        @(posedge clk);
        #1;
        sw_store_valid = 1'b1;
        sw_store_index = r.index;
        sw_store_mask  = r.mask;
        sw_store_data  = r.data;
        @(posedge clk);
        #1 sw_store_valid = 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!sw_write_done && t < TIMEOUT);
        if (!sw_write_done) give_up("sw_write_done");
    endtask

    // Holds the valid until ready, then counts the cycles up to the done pulse
    task automatic do_read(input row_t r, input bit fetch);
        int t;
        int grant_cyc;
        @(posedge clk);
        #1;
        if (fetch) begin
            pc_index = r.index;
            pc_index_valid = 1'b1;
        end else begin
            lw_index = r.index;
            lw_index_valid = 1'b1;
        end
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!(fetch ? pc_index_ready : lw_index_ready) && t < TIMEOUT);
        if (!(fetch ? pc_index_ready : lw_index_ready)) give_up("a read ready");
        grant_cyc = cycle;
        @(posedge clk);
        #1;
        pc_index_valid = 1'b0;
        lw_index_valid = 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!(fetch ? ib_read_done : lw_read_done) && t < TIMEOUT);
        if (!(fetch ? ib_read_done : lw_read_done)) give_up("a read done");
        check_cycles("grant to done", cycle - grant_cyc, DDR_LATENCY + 1);
        if (fetch) check_line("fetch line", arb2ib_read_inst, r.exp_line);
        else check_word("load word", arb2lw_read_data, r.exp_word);
    endtask

    // Store queued, then load and fetch held together
    task automatic do_parallel(input row_t r);
        int t;
        bit lw_rdy;
        bit pc_rdy;
        int done_log[$];
        int rdy_log[$];
        wait_not_full();
        @(posedge clk);
        #1;
        sw_store_valid = 1'b1;
        sw_store_index = r.index;
        sw_store_mask  = r.mask;
        sw_store_data  = r.data;
        @(posedge clk);
        #1;
        sw_store_valid = 1'b0;
        lw_index = r.index;
        pc_index = r.index;
        lw_index_valid = 1'b1;
        pc_index_valid = 1'b1;
        t = 0;
        while (done_log.size() < 3 && t < TIMEOUT) begin
            @(negedge clk);
            lw_rdy = lw_index_ready;  // Grant pulses seen in this cycle
            pc_rdy = pc_index_ready;
            if (lw_rdy) rdy_log.push_back(1);
            if (pc_rdy) rdy_log.push_back(2);
            if (sw_write_done) done_log.push_back(0);
            if (lw_read_done) begin
                done_log.push_back(1);
                check_word("parallel load", arb2lw_read_data, r.exp_word);
            end
            if (ib_read_done) begin
                done_log.push_back(2);
                check_line("parallel fetch", arb2ib_read_inst, r.exp_line);
            end
            @(posedge clk);
            #1;
            if (lw_rdy) lw_index_valid = 1'b0;  // Dropped the cycle after ready
            if (pc_rdy) pc_index_valid = 1'b0;
            t++;
        end
        if (done_log.size() < 3) give_up("the parallel done strobes");
        for (int i = 0; i < 3; i++) check_order("done order", i, done_log[i], i);
        for (int i = 0; i < rdy_log.size(); i++) check_order("ready order", i, rdy_log[i], i + 1);
        if (rdy_log.size() != 2) check_cycles("ready pulse count", rdy_log.size(), 2);
    endtask

    // Back-to-back stores while a load keeps the memory busy
    task automatic do_fill(input row_t r);
        int t;
        int step;
        int sw_seen;
        int grant_cyc;
        bit lw_seen;
        bit full_seen;
        do_read_ready_load(r.index, grant_cyc);
        step = 0;
        sw_seen = 0;
        lw_seen = 0;
        full_seen = 0;
        t = 0;
        while ((!lw_seen || sw_seen < SWQ_DEPTH) && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            lw_index_valid = 1'b0;
            sw_store_valid = (step < SWQ_DEPTH);
            if (step < SWQ_DEPTH) begin
                sw_store_index = r.index + DDR_INDEX_W'(9 * (step + 1));
                sw_store_mask  = '1;
                sw_store_data  = fill_data[step];
            end
            step++;
            @(negedge clk);
            if (sw_store_full) full_seen = 1'b1;
            if (sw_write_done) sw_seen++;
            if (lw_read_done) begin
                lw_seen = 1'b1;
                check_cycles("load under fill", cycle - grant_cyc, DDR_LATENCY + 1);
                check_word("load under fill", arb2lw_read_data, r.exp_word);
            end
            t++;
        end
        if (!lw_seen || sw_seen < SWQ_DEPTH) give_up("the fill completions");
        check_flag("sw_store_full after fill", full_seen, 1'b1);
    endtask

    task automatic do_read_ready_load(input logic [DDR_INDEX_W-1:0] idx, output int grant_cyc);
        int t;
        @(posedge clk);
        #1;
        lw_index = idx;
        lw_index_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!lw_index_ready && t < TIMEOUT);
        if (!lw_index_ready) give_up("lw_index_ready");
        grant_cyc = cycle;
    endtask

    function automatic row_t make_row(input logic [2:0] kind, input int idx,
                                      input logic [WORD_W-1:0] mask);
        row_t r;
        r = '0;
        r.kind  = kind;
        r.index = DDR_INDEX_W'(idx);
        r.mask  = mask;
        return r;
    endfunction

    initial begin
        int t;
        sw_store_valid = 1'b0;
        sw_store_index = '0;
        sw_store_mask  = '0;
        sw_store_data  = '0;
        lw_index       = '0;
        lw_index_valid = 1'b0;
        pc_index       = '0;
        pc_index_valid = 1'b0;
        void'($urandom(32'h5d84));

        rows[0]  = make_row(K_LOAD, 5, '0);  // Unwritten word
        rows[1]  = make_row(K_STORE, 10, 64'hffff_0000_ffff_0000);
        rows[2]  = make_row(K_STORE, 10, 64'h00ff_ff00_0000_00ff);  // Merges with the first
        rows[3]  = make_row(K_LOAD, 10, '0);
        rows[4]  = make_row(K_LOAD, 138, '0);  // Line number wraps onto index 10
        rows[5]  = make_row(K_STORE, 13, '1);
        rows[6]  = make_row(K_FETCH, 8, '0);
        rows[7]  = make_row(K_PAR, 20, 64'hf0f0_f0f0_f0f0_f0f0);
        rows[8]  = make_row(K_FILL, 21, '0);
        rows[9]  = make_row(K_LOAD, 30, '0);
        rows[10] = make_row(K_LOAD, 39, '0);
        rows[11] = make_row(K_LOAD, 48, '0);
        rows[12] = make_row(K_FETCH, 57, '0);

        // Expected values follow the write rule on the reference memory
        for (int i = 0; i < MEM_LINES; i++) ref_mem[i] = '0;
        for (int i = 0; i < NROWS; i++) begin
            if (rows[i].kind == K_STORE || rows[i].kind == K_PAR) begin
                rows[i].data = {$urandom, $urandom};
                ref_write(rows[i].index, rows[i].mask, rows[i].data);
            end
            rows[i].exp_word =
                ref_mem[line_of(rows[i].index)].words[rows[i].index[WORD_SEL_W-1:0]];
            rows[i].exp_line = ref_mem[line_of(rows[i].index)];
            if (rows[i].kind == K_FILL) begin
                for (int k = 0; k < SWQ_DEPTH; k++) begin
                    fill_data[k] = {$urandom, $urandom};
                    ref_write(rows[i].index + DDR_INDEX_W'(9 * (k + 1)), '1, fill_data[k]);
                end
            end
        end

        t = 0;
        while (!arst_n && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (!arst_n) give_up("reset release");
        @(negedge clk);
        check_flag("sw_write_done after reset", sw_write_done, 1'b0);
        check_flag("lw_read_done after reset", lw_read_done, 1'b0);
        check_flag("ib_read_done after reset", ib_read_done, 1'b0);
        check_flag("sw_store_full after reset", sw_store_full, 1'b0);

        for (int i = 0; i < NROWS; i++) begin
            case (rows[i].kind)
                K_STORE: do_store(rows[i]);
                K_LOAD:  do_read(rows[i], 1'b0);
                K_FETCH: do_read(rows[i], 1'b1);
                K_PAR:   do_parallel(rows[i]);
                default: do_fill(rows[i]);
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Errors: %0d value, %0d order, 0 timeout", val_errs, order_errs);
        if (val_errs == 0 && order_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
